// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

    // Instruction word from the top: opcode, X, Y, Z
    localparam int OPC_BITS = 4;
    localparam int REG_BITS = 3;    // Each field adds one indirect flag above this

    localparam logic [OPC_BITS-1:0] OP_MOV  = 4'h0;
    localparam logic [OPC_BITS-1:0] OP_ADD  = 4'h1;
    localparam logic [OPC_BITS-1:0] OP_SUB  = 4'h2;
    localparam logic [OPC_BITS-1:0] OP_MUL  = 4'h3;
    localparam logic [OPC_BITS-1:0] OP_DIV  = 4'h4;
    localparam logic [OPC_BITS-1:0] OP_IN   = 4'h7;
    localparam logic [OPC_BITS-1:0] OP_OUT  = 4'h8;
    localparam logic [OPC_BITS-1:0] OP_STOP = 4'hF;

    // Outer phases of the sequencer
    localparam logic [1:0] PH_FETCH   = 2'd0;
    localparam logic [1:0] PH_OPERAND = 2'd1;
    localparam logic [1:0] PH_EXEC    = 2'd2;

    localparam int PROG_START = 8;  // First instruction word
    localparam int REG_COUNT  = 8;  // Words 0 to 7 serve as registers

    localparam logic [1:0] ALU_ADD = 2'd0;
    localparam logic [1:0] ALU_SUB = 2'd1;
    localparam logic [1:0] ALU_MUL = 2'd2;
    localparam logic [1:0] ALU_DIV = 2'd3;

    // Operand slots read by each opcode, bit 2 is X and bit 0 is Z
    // MOV keeps its Z field as a condition, so Z is not read
    function automatic logic [2:0] op_uses(input logic [OPC_BITS-1:0] opc);
        case (opc)
            OP_MOV:                         op_uses = 3'b110;
            OP_ADD, OP_SUB, OP_MUL, OP_DIV: op_uses = 3'b111;
            OP_IN:                          op_uses = 3'b100;  // Destination only
            OP_OUT:                         op_uses = 3'b100;
            default:                        op_uses = 3'b000;
        endcase
    endfunction

endpackage

// ==== verilog/cpu_alu.sv ====
`timescale 1ns/10ps

module cpu_alu #(
    parameter int DATA_WIDTH = 16
) (
    input  logic [DATA_WIDTH-1:0] a,
    input  logic [DATA_WIDTH-1:0] b,
    input  logic [1:0]            op,
    output logic [DATA_WIDTH-1:0] f
);

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD: f = a + b;    // Wraps
            cpu_pkg::ALU_SUB: f = a - b;
            cpu_pkg::ALU_MUL: f = a * b;    // Low half of the product
            cpu_pkg::ALU_DIV: begin
                // Unsigned, zero divisor gives all ones
                if (b == '0)
                    f = '1;
                else
                    f = a / b;
            end
        endcase
    end

endmodule

// ==== verilog/cpu_datapath.sv ====
`timescale 1ns/10ps

module cpu_datapath #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] mem,
    input  logic [DATA_WIDTH-1:0] in,
    input  logic                  mar_from_pc,
    input  logic                  mar_from_field,
    input  logic                  mar_from_mdr,
    input  logic                  mar_ld,
    input  logic                  bus_issue,
    input  logic                  mdr_ld,
    input  logic                  ir_ld,
    input  logic                  pc_inc,
    input  logic                  dest_from_field,
    input  logic                  dest_from_mdr,
    input  logic                  opnd_ld,
    input  logic                  write_en,
    input  logic                  out_ld,
    input  logic                  halt,
    input  logic [1:0]            opnd_sel,
    output logic [DATA_WIDTH-1:0] ir,
    output logic [ADDR_WIDTH-1:0] addr,
    output logic [ADDR_WIDTH-1:0] pc,
    output logic [DATA_WIDTH-1:0] data,
    output logic [DATA_WIDTH-1:0] out,
    output logic                  we,
    output logic                  status
);

    localparam int FIELD_BITS    = cpu_pkg::REG_BITS + 1;
    localparam int OPC_LSB       = 3 * FIELD_BITS;
    localparam int REG_ADDR_BITS = $clog2(cpu_pkg::REG_COUNT);

    logic [ADDR_WIDTH-1:0]        mar;
    logic [ADDR_WIDTH-1:0]        dest;     // Address of X, direct or via pointer
    logic [DATA_WIDTH-1:0]        mdr;
    logic [DATA_WIDTH-1:0]        x_val;
    logic [DATA_WIDTH-1:0]        y_val;
    logic [DATA_WIDTH-1:0]        z_val;
    logic [cpu_pkg::OPC_BITS-1:0] opc;
    logic [cpu_pkg::REG_BITS-1:0] sel_reg;
    logic [ADDR_WIDTH-1:0]        reg_addr;
    logic [ADDR_WIDTH-1:0]        ptr;
    logic [1:0]                   alu_op;
    logic [DATA_WIDTH-1:0]        alu_f;
    logic [DATA_WIDTH-1:0]        wr_data;

    assign opc      = ir[OPC_LSB +: cpu_pkg::OPC_BITS];
    assign reg_addr = ADDR_WIDTH'(sel_reg[REG_ADDR_BITS-1:0]);
    assign ptr      = mdr[ADDR_WIDTH-1:0];

    // Register number of the slot the sequencer is working on
    always_comb begin
        case (opnd_sel)
            2'd0:    sel_reg = ir[2*FIELD_BITS +: cpu_pkg::REG_BITS];
            2'd1:    sel_reg = ir[FIELD_BITS +: cpu_pkg::REG_BITS];
            default: sel_reg = ir[0 +: cpu_pkg::REG_BITS];
        endcase
    end

    always_comb begin
        case (opc)
            cpu_pkg::OP_SUB: alu_op = cpu_pkg::ALU_SUB;
            cpu_pkg::OP_MUL: alu_op = cpu_pkg::ALU_MUL;
            cpu_pkg::OP_DIV: alu_op = cpu_pkg::ALU_DIV;
            default:         alu_op = cpu_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        case (opc)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
            cpu_pkg::OP_MUL, cpu_pkg::OP_DIV: wr_data = alu_f;
            cpu_pkg::OP_IN:                   wr_data = in;
            default:                          wr_data = y_val;   // MOV
        endcase
    end

    cpu_alu #(
        .DATA_WIDTH(DATA_WIDTH)
    ) alu_i (
        .a(y_val),
        .b(z_val),
        .op(alu_op),
        .f(alu_f)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= ADDR_WIDTH'(cpu_pkg::PROG_START);
            ir     <= '0;
            addr   <= '0;
            we     <= 1'b0;
            out    <= '0;
            status <= 1'b0;
        end else begin
            if (pc_inc)
                pc <= pc + 1'b1;
            if (ir_ld)
                ir <= mdr;
            if (bus_issue)
                addr <= mar;            // Read address
            else if (write_en)
                addr <= dest;
            we <= write_en;             // High only in the cycle after the strobe
            if (out_ld)
                out <= x_val;
            if (halt)
                status <= 1'b1;         // Sticky until reset
        end
    end

    always_ff @(posedge clk) begin
        if (mar_ld) begin
            if (mar_from_pc)
                mar <= pc;
            else if (mar_from_field)
                mar <= reg_addr;
            else if (mar_from_mdr)
                mar <= ptr;
        end
        if (mdr_ld)
            mdr <= mem;                 // Memory answers in the same cycle
        if (opnd_ld) begin
            case (opnd_sel)
                2'd0:    x_val <= mdr;
                2'd1:    y_val <= mdr;
                default: z_val <= mdr;
            endcase
        end
        if (dest_from_field)
            dest <= reg_addr;
        else if (dest_from_mdr)
            dest <= ptr;
        if (write_en)
            data <= wr_data;
    end

endmodule

// ==== verilog/cpu_sequencer.sv ====
`timescale 1ns/10ps

module cpu_sequencer #(
    parameter int DATA_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] ir,
    output logic                  mar_from_pc,
    output logic                  mar_from_field,
    output logic                  mar_from_mdr,
    output logic                  mar_ld,
    output logic                  bus_issue,
    output logic                  mdr_ld,
    output logic                  ir_ld,
    output logic                  pc_inc,
    output logic                  dest_from_field,
    output logic                  dest_from_mdr,
    output logic                  opnd_ld,
    output logic                  write_en,
    output logic                  out_ld,
    output logic                  halt,
    output logic [1:0]            opnd_sel
);

    localparam int FIELD_BITS = cpu_pkg::REG_BITS + 1;
    localparam int OPC_LSB    = 3 * FIELD_BITS;

    localparam logic [1:0] SLOT_X    = 2'd0;
    localparam logic [1:0] SLOT_DONE = 2'd3;  // Closing cycle of the operand phase

    logic [1:0] phase, phase_next;
    logic [1:0] fetch_step, fetch_step_next;
    logic [2:0] opnd_step, opnd_step_next;    // 0..3 direct, 4..6 through pointer
    logic [1:0] slot, slot_next;
    logic       exec_step, exec_step_next;

    logic [cpu_pkg::OPC_BITS-1:0] opc;
    logic [FIELD_BITS-1:0]        field;
    logic [2:0]                   uses;
    logic [3:0]                   slot_mask;
    logic                         slot_used;
    logic                         slot_ind;
    logic                         z_zero;

    assign opc       = ir[OPC_LSB +: cpu_pkg::OPC_BITS];
    assign uses      = cpu_pkg::op_uses(opc);
    assign slot_mask = {1'b0, uses[0], uses[1], uses[2]};  // Indexed by slot
    assign slot_used = slot_mask[slot];
    assign slot_ind  = field[FIELD_BITS-1];
    assign z_zero    = (ir[0 +: FIELD_BITS] == '0);   // MOV condition
    assign opnd_sel  = slot;

    // Field of the slot being read
    always_comb begin
        case (slot)
            2'd0:    field = ir[2*FIELD_BITS +: FIELD_BITS];
            2'd1:    field = ir[FIELD_BITS +: FIELD_BITS];
            default: field = ir[0 +: FIELD_BITS];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= cpu_pkg::PH_FETCH;
            fetch_step <= 2'd0;
            opnd_step  <= 3'd0;
            slot       <= SLOT_X;
            exec_step  <= 1'b0;
        end else begin
            phase      <= phase_next;
            fetch_step <= fetch_step_next;
            opnd_step  <= opnd_step_next;
            slot       <= slot_next;
            exec_step  <= exec_step_next;
        end
    end

    always_comb begin
        phase_next      = phase;
        fetch_step_next = fetch_step;
        opnd_step_next  = opnd_step;
        slot_next       = slot;
        exec_step_next  = exec_step;

        mar_from_pc     = 1'b0;
        mar_from_field  = 1'b0;
        mar_from_mdr    = 1'b0;
        mar_ld          = 1'b0;
        bus_issue       = 1'b0;
        mdr_ld          = 1'b0;
        ir_ld           = 1'b0;
        pc_inc          = 1'b0;
        dest_from_field = 1'b0;
        dest_from_mdr   = 1'b0;
        opnd_ld         = 1'b0;
        write_en        = 1'b0;
        out_ld          = 1'b0;
        halt            = 1'b0;

        case (phase)
            cpu_pkg::PH_FETCH: begin
                fetch_step_next = fetch_step + 2'd1;   // Wraps to 0 after the IR load
                case (fetch_step)
                    2'd0: begin
                        mar_from_pc = 1'b1;
                        mar_ld      = 1'b1;
                    end
                    2'd1:    bus_issue = 1'b1;
                    2'd2:    mdr_ld    = 1'b1;
                    default: begin
                        ir_ld      = 1'b1;
                        pc_inc     = 1'b1;
                        phase_next = cpu_pkg::PH_OPERAND;
                    end
                endcase
            end

            cpu_pkg::PH_OPERAND: begin
                if (slot == SLOT_DONE) begin
                    slot_next  = SLOT_X;
                    phase_next = cpu_pkg::PH_EXEC;
                end else if (!slot_used) begin
                    slot_next = slot + 2'd1;           // One idle cycle per unused slot
                end else begin
                    opnd_step_next = opnd_step + 3'd1;
                    case (opnd_step)
                        3'd0: begin
                            mar_from_field = 1'b1;
                            mar_ld         = 1'b1;
                        end
                        3'd1, 3'd4: bus_issue = 1'b1;
                        3'd2, 3'd5: mdr_ld    = 1'b1;
                        3'd3: begin
                            if (slot_ind) begin
                                // MDR holds a pointer, read again through it
                                mar_from_mdr  = 1'b1;
                                mar_ld        = 1'b1;
                                dest_from_mdr = (slot == SLOT_X);
                            end else begin
                                opnd_ld         = 1'b1;
                                dest_from_field = (slot == SLOT_X);
                                opnd_step_next  = 3'd0;
                                slot_next       = slot + 2'd1;
                            end
                        end
                        default: begin
                            opnd_ld        = 1'b1;   // Value behind the pointer
                            opnd_step_next = 3'd0;
                            slot_next      = slot + 2'd1;
                        end
                    endcase
                end
            end

            cpu_pkg::PH_EXEC: begin
                if (!exec_step) begin
                    exec_step_next = 1'b1;
                    case (opc)
                        cpu_pkg::OP_MOV: write_en = z_zero;
                        cpu_pkg::OP_ADD, cpu_pkg::OP_SUB,
                        cpu_pkg::OP_MUL, cpu_pkg::OP_DIV,
                        cpu_pkg::OP_IN:  write_en = 1'b1;
                        cpu_pkg::OP_OUT: out_ld   = 1'b1;
                        cpu_pkg::OP_STOP: begin
                            halt           = 1'b1;   // Parked here for good
                            exec_step_next = 1'b0;
                        end
                        default: ;
                    endcase
                end else begin
                    // Bus write happens now, then back to fetch
                    exec_step_next = 1'b0;
                    phase_next     = cpu_pkg::PH_FETCH;
                end
            end

            default: phase_next = cpu_pkg::PH_FETCH;
        endcase
    end

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/10ps

module cpu #(
    parameter int ADDR_WIDTH = 6,
    parameter int DATA_WIDTH = 16     // At least 16, one instruction per word
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [DATA_WIDTH-1:0] mem,
    input  logic [DATA_WIDTH-1:0] in,
    output logic                  status,
    output logic                  we,
    output logic [ADDR_WIDTH-1:0] addr,
    output logic [DATA_WIDTH-1:0] data,
    output logic [DATA_WIDTH-1:0] out,
    output logic [ADDR_WIDTH-1:0] pc
);

    logic [DATA_WIDTH-1:0] ir;
    logic                  mar_from_pc;
    logic                  mar_from_field;
    logic                  mar_from_mdr;
    logic                  mar_ld;
    logic                  bus_issue;
    logic                  mdr_ld;
    logic                  ir_ld;
    logic                  pc_inc;
    logic                  dest_from_field;
    logic                  dest_from_mdr;
    logic                  opnd_ld;
    logic                  write_en;
    logic                  out_ld;
    logic                  halt;
    logic [1:0]            opnd_sel;

    cpu_sequencer #(
        .DATA_WIDTH(DATA_WIDTH)
    ) seq_i (
        .clk(clk), .rst_n(rst_n), .ir(ir),
        .mar_from_pc(mar_from_pc), .mar_from_field(mar_from_field),
        .mar_from_mdr(mar_from_mdr), .mar_ld(mar_ld),
        .bus_issue(bus_issue), .mdr_ld(mdr_ld), .ir_ld(ir_ld), .pc_inc(pc_inc),
        .dest_from_field(dest_from_field), .dest_from_mdr(dest_from_mdr),
        .opnd_ld(opnd_ld), .write_en(write_en), .out_ld(out_ld), .halt(halt),
        .opnd_sel(opnd_sel)
    );

    cpu_datapath #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) dp_i (
        .clk(clk), .rst_n(rst_n), .mem(mem), .in(in),
        .mar_from_pc(mar_from_pc), .mar_from_field(mar_from_field),
        .mar_from_mdr(mar_from_mdr), .mar_ld(mar_ld),
        .bus_issue(bus_issue), .mdr_ld(mdr_ld), .ir_ld(ir_ld), .pc_inc(pc_inc),
        .dest_from_field(dest_from_field), .dest_from_mdr(dest_from_mdr),
        .opnd_ld(opnd_ld), .write_en(write_en), .out_ld(out_ld), .halt(halt),
        .opnd_sel(opnd_sel),
        .ir(ir), .addr(addr), .pc(pc), .data(data), .out(out),
        .we(we), .status(status)
    );

endmodule

// ==== verification/cpu_chk.sv ====
`timescale 1ns/10ps

module cpu_chk #(
    parameter int ADDR_WIDTH = 6
) (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  we,
    input logic                  status,
    input logic [ADDR_WIDTH-1:0] pc
);

    int fails = 0;   // Assertion failures so far

    // Write strobe lasts one cycle
    we_single: assert property (@(posedge clk) disable iff (!rst_n) we |=> !we)
        else begin
            $error("we high for two cycles in a row");
            fails++;
        end

    status_sticky: assert property (@(posedge clk) disable iff (!rst_n) status |=> status)
        else begin
            $error("status fell without reset");
            fails++;
        end

    no_write_halted: assert property (@(posedge clk) disable iff (!rst_n) status |-> !we)
        else begin
            $error("write while halted");
            fails++;
        end

    pc_frozen: assert property (@(posedge clk) disable iff (!rst_n) status |=> $stable(pc))
        else begin
            $error("pc moved while halted");
            fails++;
        end

endmodule

// ==== verification/cpu_tb.sv ====
`timescale 1ns/10ps

module cpu_tb;

    localparam int ADDR_WIDTH  = 6;
    localparam int DATA_WIDTH  = 16;
    localparam int MEM_WORDS   = 1 << ADDR_WIDTH;
    localparam int NUM_TESTS   = 15;
    localparam int TEST_CYCLES = 8 + 2 * 28 + 10;   // Reset plus two longest instructions plus slack

    typedef struct packed {
        logic [3:0]  op;
        logic [3:0]  x;
        logic [3:0]  y;
        logic [3:0]  z;
        logic [15:0] in_word;
        logic [2:0]  dest_reg;    // Register named as destination
        logic [7:0]  zero_mask;   // Registers cleared after the random fill
        logic        exp_wr;
        logic        exp_out;
    } test_t;

    logic                  clk;
    logic                  rst_n;
    logic [DATA_WIDTH-1:0] mem;
    logic [DATA_WIDTH-1:0] in;
    logic                  status;
    logic                  we;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    logic [DATA_WIDTH-1:0] out;
    logic [ADDR_WIDTH-1:0] pc;

    logic [DATA_WIDTH-1:0] ram [MEM_WORDS] = '{default: '0};
    logic [DATA_WIDTH-1:0] image [MEM_WORDS];   // Contents loaded during reset
    logic                  mem_load;
    logic [16:0]           lfsr;
    test_t                 tests [NUM_TESTS];
    int                    errors;
    int                    passed;

    cpu #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .DATA_WIDTH(DATA_WIDTH)
    ) cpu_i (
        .clk(clk), .rst_n(rst_n), .mem(mem), .in(in), .status(status), .we(we),
        .addr(addr), .data(data), .out(out), .pc(pc)
    );

    bind cpu cpu_chk #(.ADDR_WIDTH(ADDR_WIDTH)) chk_i (
        .clk(clk), .rst_n(rst_n), .we(we), .status(status), .pc(pc)
    );

    // Memory model with a combinational read
    assign mem = ram[addr];

    always @(posedge clk) begin
        if (mem_load)
            ram <= image;
        else if (we)
            ram[addr] <= data;
    end

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // 17-bit Fibonacci LFSR with taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        lfsr_next = {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic random_word(output logic [15:0] w);
        w = '0;
        repeat (16) begin
            lfsr = lfsr_next(lfsr);
            w    = {w[14:0], lfsr[0]};
        end
    endtask

    function automatic logic [15:0] fill_word(input int a);
        fill_word = 16'(a) * 16'h2F1B ^ 16'h5A3C;
    endfunction

    // Word an operand field refers to directly or through its pointer
    function automatic logic [ADDR_WIDTH-1:0] field_addr(input logic [3:0] f);
        if (f[3])
            field_addr = image[f[2:0]][ADDR_WIDTH-1:0];
        else
            field_addr = {3'b000, f[2:0]};
    endfunction

    task automatic load_table();
        //            op                x     y     z     in        dst   zero   wr    out
        tests[0]  = '{cpu_pkg::OP_ADD,  4'h1, 4'h2, 4'h3, 16'h0000, 3'd1, 8'h00, 1'b1, 1'b0};
        tests[1]  = '{cpu_pkg::OP_SUB,  4'h0, 4'h5, 4'h6, 16'h0000, 3'd0, 8'h00, 1'b1, 1'b0};
        tests[2]  = '{cpu_pkg::OP_MUL,  4'h7, 4'h4, 4'h4, 16'h0000, 3'd7, 8'h00, 1'b1, 1'b0};
        tests[3]  = '{cpu_pkg::OP_DIV,  4'h2, 4'h3, 4'h1, 16'h0000, 3'd2, 8'h00, 1'b1, 1'b0};
        tests[4]  = '{cpu_pkg::OP_DIV,  4'h3, 4'h4, 4'h5, 16'h0000, 3'd3, 8'h20, 1'b1, 1'b0};
        tests[5]  = '{cpu_pkg::OP_ADD,  4'h9, 4'hA, 4'h3, 16'h0000, 3'd1, 8'h00, 1'b1, 1'b0};
        tests[6]  = '{cpu_pkg::OP_SUB,  4'h4, 4'hD, 4'hE, 16'h0000, 3'd4, 8'h00, 1'b1, 1'b0};
        tests[7]  = '{cpu_pkg::OP_MUL,  4'h8, 4'h1, 4'h2, 16'h0000, 3'd0, 8'h00, 1'b1, 1'b0};
        tests[8]  = '{cpu_pkg::OP_DIV,  4'h1, 4'hB, 4'hA, 16'h0000, 3'd1, 8'h00, 1'b1, 1'b0};
        tests[9]  = '{cpu_pkg::OP_MOV,  4'h2, 4'h6, 4'h0, 16'h0000, 3'd2, 8'h00, 1'b1, 1'b0};
        tests[10] = '{cpu_pkg::OP_MOV,  4'h3, 4'h1, 4'h5, 16'h0000, 3'd3, 8'h00, 1'b0, 1'b0};
        tests[11] = '{cpu_pkg::OP_MOV,  4'hB, 4'hC, 4'h0, 16'h0000, 3'd3, 8'h00, 1'b1, 1'b0};
        tests[12] = '{cpu_pkg::OP_IN,   4'h5, 4'h0, 4'h0, 16'hBEEF, 3'd5, 8'h00, 1'b1, 1'b0};
        tests[13] = '{cpu_pkg::OP_IN,   4'hE, 4'h0, 4'h0, 16'h1234, 3'd6, 8'h00, 1'b1, 1'b0};
        tests[14] = '{cpu_pkg::OP_OUT,  4'h9, 4'h0, 4'h0, 16'h0000, 3'd1, 8'h00, 1'b0, 1'b1};
    endtask

    task automatic run_test(input int n);
        test_t                 t;
        logic [7:0]            ptr_mask;
        logic [15:0]           w;
        logic [15:0]           y_v;
        logic [15:0]           z_v;
        logic [15:0]           res;
        logic [ADDR_WIDTH-1:0] dest;
        logic [15:0]           expect_mem [MEM_WORDS];
        int                    errors_before;
        int                    i;

        t             = tests[n];
        errors_before = errors;
        ptr_mask      = '0;
        if (t.x[3]) ptr_mask[t.x[2:0]] = 1'b1;
        if (t.y[3]) ptr_mask[t.y[2:0]] = 1'b1;
        if (t.z[3]) ptr_mask[t.z[2:0]] = 1'b1;
        for (i = 0; i < cpu_pkg::REG_COUNT; i++) begin
            random_word(w);
            if (ptr_mask[i])
                w = (w & 16'h003F) | 16'h0010;   // Pointer into 16..63
            if (t.zero_mask[i])
                w = '0;
            image[i] = w;
        end
        for (i = cpu_pkg::REG_COUNT; i < MEM_WORDS; i++)
            image[i] = fill_word(i);
        image[cpu_pkg::PROG_START]     = {t.op, t.x, t.y, t.z};
        image[cpu_pkg::PROG_START + 1] = {cpu_pkg::OP_STOP, 12'h000};

        @(negedge clk);
        rst_n    = 1'b0;
        in       = t.in_word;
        mem_load = 1'b1;
        @(negedge clk);
        mem_load = 1'b0;
        repeat (7) @(negedge clk);
        if (pc !== 6'(cpu_pkg::PROG_START) || we !== 1'b0 || status !== 1'b0 ||
            addr !== '0 || out !== '0) begin
            $display("ERROR %0t: test %0d reset state pc=%0d we=%b status=%b addr=%0d out=%h",
                     $time, n, pc, we, status, addr, out);
            errors++;
        end
        rst_n = 1'b1;
        while (status !== 1'b1)
            @(negedge clk);
        repeat (4) @(negedge clk);   // Halted state has to hold

        y_v  = image[field_addr(t.y)];
        z_v  = image[field_addr(t.z)];
        dest = t.x[3] ? image[t.dest_reg][ADDR_WIDTH-1:0] : ADDR_WIDTH'(t.dest_reg);
        case (t.op)
            cpu_pkg::OP_ADD: res = y_v + z_v;
            cpu_pkg::OP_SUB: res = y_v - z_v;
            cpu_pkg::OP_MUL: res = y_v * z_v;            // Low half
            cpu_pkg::OP_DIV: res = (z_v == 16'h0000) ? 16'hFFFF : y_v / z_v;
            cpu_pkg::OP_IN:  res = t.in_word;
            default:         res = y_v;
        endcase
        expect_mem = image;
        if (t.exp_wr)
            expect_mem[dest] = res;

        for (i = 0; i < MEM_WORDS; i++) begin
            if (ram[i] !== expect_mem[i]) begin
                $display("ERROR %0t: test %0d word %0d is %h, expected %h",
                         $time, n, i, ram[i], expect_mem[i]);
                errors++;
            end
        end
        if (out !== (t.exp_out ? image[dest] : 16'h0000)) begin
            $display("ERROR %0t: test %0d out is %h", $time, n, out);
            errors++;
        end
        if (pc !== 6'(cpu_pkg::PROG_START + 2) || we !== 1'b0) begin
            $display("ERROR %0t: test %0d halted with pc=%0d we=%b", $time, n, pc, we);
            errors++;
        end
        if (errors == errors_before) begin
            passed++;
            $display("Test %0d op %h passed", n, t.op);
        end else begin
            $display("Test %0d op %h failed", n, t.op);
        end
    endtask

    initial begin
        repeat (NUM_TESTS * TEST_CYCLES) @(posedge clk);
        $display("Timeout: the program never halted");
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        in       = '0;
        mem_load = 1'b0;
        lfsr     = 17'd66931;
        errors   = 0;
        passed   = 0;
        load_table();
        for (int n = 0; n < NUM_TESTS; n++)
            run_test(n);
        errors += cpu_i.chk_i.fails;   // Assertion failures
        $display("%0d tests, %0d passed, %0d errors", NUM_TESTS, passed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_datapath.sv
verilog/cpu_sequencer.sv
verilog/cpu.sv
verification/cpu_chk.sv
verification/cpu_tb.sv

// ==== Makefile ====
SIM     = verilator
FLAGS   = --binary --timing --assert -j 0
TOP     = cpu_tb
FLIST   = flist.f
OBJ_DIR = obj_dir
BIN     = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Finished with no errors$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
